/* verilog.f */
hdl/mips_pkg.sv
hdl/mem_bus_if.sv
hdl/mips_alu.sv
hdl/mips_regfile.sv
hdl/mips_control.sv
hdl/mips_core.sv
hdl/mips_memory.sv
hdl/mips_top.sv
verif/tb_mips.sv

/* run.sh */
#!/bin/sh
# build the tb_mips testbench with Verilator, run it, judge by the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_mips -f verilog.f -o sim_mips \
	|| { echo "verilator build failed"; exit 1; }
./obj_dir/sim_mips > sim.log 2>&1
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" && exit 0 \
	|| { echo "simulation failed, see sim.log"; exit 1; }

/* verif/tb_mips.sv */
`timescale 1ns/10ps

module tb_mips;
	import mips_pkg::*;

	localparam int n_tests    = 6;
	localparam int n_instr    = 40;
	localparam int end_pc     = 156;    // byte address of the j-to-self
	// load + reset + 5 cycles per instruction + margin, every test
	localparam int max_cycles = n_tests * (mem_words + 16 + n_instr * 5 + 100);

	logic              clk, rstb, load_ena;
	logic [mem_aw-1:0] load_addr;
	logic [xlen-1:0]   load_data, pc, reg_wr_data, mem_wr_addr, mem_wr_data;
	logic              reg_wr_valid, mem_wr_valid;
	logic [4:0]        reg_wr_addr;

	logic [xlen-1:0] image [mem_words];     // what the host port loads
	logic [xlen-1:0] m_mem [mem_words];     // model memory
	logic [xlen-1:0] m_reg [32];            // model register file
	logic [4:0]      exp_ra [$];            // expected reg writes, in order
	logic [xlen-1:0] exp_rd [$], exp_ma [$], exp_md [$];
	logic [xlen-1:0] exp_pc [$];            // pc values in order of change
	int errors, n_pass, n_fail;
	int cycles = 0;

	mips_top u_dut (
		.clk(clk), .rstb(rstb), .load_ena(load_ena), .load_addr(load_addr),
		.load_data(load_data), .pc(pc), .reg_wr_valid(reg_wr_valid),
		.reg_wr_addr(reg_wr_addr), .reg_wr_data(reg_wr_data),
		.mem_wr_valid(mem_wr_valid), .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > max_cycles) begin
			$display("timeout: no end of program after %0d cycles", max_cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic compare_word(input string name, input logic [xlen-1:0] got,
		input logic [xlen-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_reg_idx(input string name, input logic [4:0] got,
		input logic [4:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	function automatic logic [xlen-1:0] enc_r(logic [5:0] fn, logic [4:0] rs, rt, rd, sh);
		return {op_rtype, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [xlen-1:0] enc_i(logic [5:0] op, logic [4:0] rs, rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [xlen-1:0] enc_j(logic [5:0] op, logic [25:0] tgt);
		return {op, tgt};
	endfunction

	// layout: body 0..33, 34 skips the subroutine, 35..38 subroutine, 39 j-to-self
	task automatic gen_program();
		int jal_at, k, off, word, last_sw;
		logic [4:0]  rs, rt, rd;
		logic [15:0] imm;
		jal_at  = $urandom_range(30, 4);
		last_sw = 160;
		for (int w = 0; w < mem_words; w++)
			image[w] = {8'h5a, 8'(w), ~8'(w), 8'(w * 7)};   // distinct per word
		for (int i = 0; i < 38; i++) begin
			if (i == 34)
				continue;
			k   = (i < 34) ? $urandom_range(13, 0) : $urandom_range(8, 0);
			off = $urandom_range(3, 1);
			// branches stay inside the body and never skip the jal
			if (k >= 11 && (i + off > 33 || (jal_at > i && jal_at <= i + off)))
				k = 6;
			rs   = 5'($urandom_range(15, 0));   // $0 included as a destination
			rt   = 5'($urandom_range(15, 0));
			rd   = 5'($urandom_range(15, 0));
			imm  = 16'($urandom);
			word = $urandom_range(1, 0) ? last_sw : $urandom_range(191, 128);
			case (k)
				0: image[i] = enc_r(fn_addu, rs, rt, rd, 5'd0);
				1: image[i] = enc_r(fn_subu, rs, rt, rd, 5'd0);
				2: image[i] = enc_r(fn_and, rs, rt, rd, 5'd0);
				3: image[i] = enc_r(fn_or, rs, rt, rd, 5'd0);
				4: image[i] = enc_r(fn_slt, rs, rt, rd, 5'd0);
				5: image[i] = enc_r(fn_sll, 5'd0, rt, rd, imm[4:0]);
				6: image[i] = enc_i(op_addiu, rs, rt, imm);
				7: image[i] = enc_i(op_andi, rs, rt, imm);
				8: image[i] = enc_i(op_ori, rs, rt, imm);
				9: image[i] = enc_i(op_lw, 5'd0, rt, 16'(word * 4));    // often after a sw
				10: begin
					last_sw  = word;
					image[i] = enc_i(op_sw, 5'd0, rt, 16'(word * 4));
				end
				11: image[i] = enc_i(op_beq, rs, $urandom_range(1, 0) ? rs : rt, 16'(off));
				12: image[i] = enc_i(op_bne, rs, $urandom_range(1, 0) ? rs : rt, 16'(off));
				default: image[i] = enc_j(op_j, 26'(i + 1 + off));
			endcase
		end
		image[34]     = enc_j(op_j, 26'd39);
		image[jal_at] = enc_j(op_jal, 26'd35);
		image[38]     = enc_r(fn_jr, reg_ra, 5'd0, 5'd0, 5'd0);
		image[39]     = enc_j(op_j, 26'd39);
	endtask

	task automatic write_reg(input logic [4:0] idx, input logic [xlen-1:0] val);
		exp_ra.push_back(idx);      // $0 still shows on the trace
		exp_rd.push_back(val);
		if (idx != 5'd0)
			m_reg[idx] = val;
	endtask

	// ISA-level model, one instruction per step
	task automatic run_model();
		logic [xlen-1:0] mpc, ins, a, b, imm_s, adr, res, fall;
		exp_ra.delete();
		exp_rd.delete();
		exp_ma.delete();
		exp_md.delete();
		exp_pc.delete();
		for (int r = 0; r < 32; r++)
			m_reg[r] = '0;
		for (int w = 0; w < mem_words; w++)
			m_mem[w] = image[w];
		mpc = '0;
		for (int step = 0; step < 200 && mpc != end_pc; step++) begin
			ins   = m_mem[mpc[mem_aw+1:2]];
			a     = m_reg[ins[25:21]];
			b     = m_reg[ins[20:16]];
			imm_s = {{16{ins[15]}}, ins[15:0]};
			adr   = a + imm_s;
			mpc   = mpc + 32'd4;
			fall  = mpc;
			exp_pc.push_back(mpc);      // fetch step
			res   = '0;
			case (ins[31:26])
				op_rtype: begin
					case (ins[5:0])
						fn_addu: res = a + b;
						fn_subu: res = a - b;
						fn_and:  res = a & b;
						fn_or:   res = a | b;
						fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						fn_sll:  res = b << ins[10:6];
						default: res = '0;
					endcase
					if (ins[5:0] == fn_jr)
						mpc = a;
					else
						write_reg(ins[15:11], res);
				end
				op_addiu: write_reg(ins[20:16], adr);
				op_andi:  write_reg(ins[20:16], a & {16'b0, ins[15:0]});
				op_ori:   write_reg(ins[20:16], a | {16'b0, ins[15:0]});
				op_lw:    write_reg(ins[20:16], m_mem[adr[mem_aw+1:2]]);
				op_sw: begin
					m_mem[adr[mem_aw+1:2]] = b;
					exp_ma.push_back(adr);
					exp_md.push_back(b);
				end
				op_beq: if (a == b) mpc = mpc + {imm_s[29:0], 2'b00};
				op_bne: if (a != b) mpc = mpc + {imm_s[29:0], 2'b00};
				op_j:   mpc = {mpc[31:28], ins[25:0], 2'b00};
				op_jal: begin
					write_reg(reg_ra, mpc);   // return address
					mpc = {mpc[31:28], ins[25:0], 2'b00};
				end
				default: ;
			endcase
			if (mpc != fall)
				exp_pc.push_back(mpc);  // taken branch or jump
		end
	endtask

	task automatic run_test(input int t);
		int quiet;
		logic [xlen-1:0] last_pc;
		errors = 0;
		quiet  = 0;
		gen_program();
		run_model();
		@(posedge clk);
		rstb <= 1'b0;
		repeat (8) @(posedge clk);
		for (int w = 0; w < mem_words; w++) begin
			load_ena  <= 1'b1;
			load_addr <= 8'(w);
			load_data <= image[w];
			@(posedge clk);
		end
		load_ena <= 1'b0;
		@(negedge clk);
		compare_word("pc", pc, '0);
		if (reg_wr_valid || mem_wr_valid) begin
			$display("write trace active while the core is held in reset");
			errors++;
		end
		@(posedge clk);
		rstb <= 1'b1;
		@(negedge clk);
		compare_word("pc", pc, '0);
		@(negedge clk);
		compare_word("pc", pc, 32'd4);     // first fetch done
		last_pc = 32'd4;
		exp_pc.delete(0);                  // first fetch step already seen
		// follow the traces until the program parks at its j-to-self
		while (quiet < 6) begin
			@(negedge clk);
			if (pc !== last_pc && exp_pc.size() != 0) begin
				compare_word("pc", pc, exp_pc.pop_front());
				last_pc = pc;
			end
			if (reg_wr_valid && exp_ra.size() == 0) begin
				$display("register write beyond the end of the expected sequence");
				errors++;
			end else if (reg_wr_valid) begin
				compare_reg_idx("reg_wr_addr", reg_wr_addr, exp_ra.pop_front());
				compare_word("reg_wr_data", reg_wr_data, exp_rd.pop_front());
			end
			if (mem_wr_valid && exp_ma.size() == 0) begin
				$display("memory write beyond the end of the expected sequence");
				errors++;
			end else if (mem_wr_valid) begin
				compare_word("mem_wr_addr", mem_wr_addr, exp_ma.pop_front());
				compare_word("mem_wr_data", mem_wr_data, exp_md.pop_front());
			end
			// pc only toggles between the j and its fall-through once parked
			if (exp_ra.size() == 0 && exp_ma.size() == 0 && exp_pc.size() == 0 &&
				(pc == end_pc || pc == end_pc + 4))
				quiet++;
			else
				quiet = 0;
		end
		if (errors == 0) begin
			n_pass++;
			$display("test %0d passed", t);
		end else begin
			n_fail++;
			$display("test %0d failed with %0d mismatches", t, errors);
		end
	endtask

	initial begin
		void'($urandom(32'h1022_a3f7));
		rstb      = 1'b0;
		load_ena  = 1'b0;
		load_addr = '0;
		load_data = '0;
		n_pass    = 0;
		n_fail    = 0;
		repeat (8) @(posedge clk);
		for (int t = 0; t < n_tests; t++)
			run_test(t);
		$display("tests passed %0d, tests failed %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* hdl/mips_top.sv */
`timescale 1ns/10ps

module mips_top (
	input  logic                        clk,
	input  logic                        rstb,
	input  logic                        load_ena,
	input  logic [mips_pkg::mem_aw-1:0] load_addr,
	input  logic [mips_pkg::xlen-1:0]   load_data,
	output logic [mips_pkg::xlen-1:0]   pc,
	output logic                        reg_wr_valid,
	output logic [4:0]                  reg_wr_addr,
	output logic [mips_pkg::xlen-1:0]   reg_wr_data,
	output logic                        mem_wr_valid,
	output logic [mips_pkg::xlen-1:0]   mem_wr_addr,
	output logic [mips_pkg::xlen-1:0]   mem_wr_data
);

	mem_bus_if u_bus ();

	mips_core u_core (
		.clk          (clk),
		.rstb         (rstb),
		.mem          (u_bus.core),
		.pc           (pc),
		.reg_wr_valid (reg_wr_valid),
		.reg_wr_addr  (reg_wr_addr),
		.reg_wr_data  (reg_wr_data)
	);

	mips_memory u_mem (
		.clk       (clk),
		.load_ena  (load_ena),
		.load_addr (load_addr),
		.load_data (load_data),
		.bus       (u_bus.mem)
	);

	// store trace straight off the bus
	assign mem_wr_valid = u_bus.wr_ena;
	assign mem_wr_addr  = u_bus.addr;
	assign mem_wr_data  = u_bus.wr_data;

endmodule

/* hdl/mips_memory.sv */
`timescale 1ns/10ps

module mips_memory (
	input  logic                        clk,
	input  logic                        load_ena,
	input  logic [mips_pkg::mem_aw-1:0] load_addr,    // word address
	input  logic [mips_pkg::xlen-1:0]   load_data,
	mem_bus_if.mem                      bus
);
	import mips_pkg::*;

	logic [xlen-1:0]   ram [mem_words];
	logic [mem_aw-1:0] bus_idx;

	// byte address to word index, upper bits ignored
	assign bus_idx = bus.addr[mem_aw+1:2];

	// combinational read, instr and data alike
	assign bus.rd_data = ram[bus_idx];

	always_ff @(posedge clk) begin
		if (load_ena)
			ram[load_addr] <= load_data;    // host preload has priority
		else if (bus.wr_ena)
			ram[bus_idx] <= bus.wr_data;
	end

	// only word stores exist, a low bit set means a bad base+offset
	a_wr_aligned: assert property (@(posedge clk)
		bus.wr_ena |-> bus.addr[1:0] == 2'b00);

endmodule

/* hdl/mips_core.sv */
`timescale 1ns/10ps

module mips_core (
	input  logic                      clk,
	input  logic                      rstb,
	mem_bus_if.core                   mem,
	output logic [mips_pkg::xlen-1:0] pc,
	output logic                      reg_wr_valid,
	output logic [4:0]                reg_wr_addr,
	output logic [mips_pkg::xlen-1:0] reg_wr_data
);
	import mips_pkg::*;

	ctrl_word_t      ctrl;
	logic [xlen-1:0] ir;        // instruction register
	logic [xlen-1:0] mdr;       // memory data register
	logic [xlen-1:0] reg_a, reg_b, alu_out;
	logic [xlen-1:0] rd1, rd2;
	logic [xlen-1:0] ext_imm;
	logic [xlen-1:0] src_a, src_b;
	logic [xlen-1:0] alu_res;
	logic            alu_zero;
	logic            pc_ena;

	mips_control u_ctrl (
		.clk   (clk),
		.rstb  (rstb),
		.instr (ir),
		.ctrl  (ctrl)
	);

	// immediate extender
	assign ext_imm = ctrl.ext_zero ? {16'b0, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};

	// alu operand muxes
	always_comb begin
		case (ctrl.src_a)
			sa_pc:    src_a = pc;
			sa_reg_a: src_a = reg_a;
			sa_shamt: src_a = {27'b0, ir[10:6]};
			default:  src_a = pc;
		endcase
		case (ctrl.src_b)
			sb_reg_b:  src_b = reg_b;
			sb_four:   src_b = 32'd4;
			sb_imm:    src_b = ext_imm;
			sb_imm_sh: src_b = {ext_imm[29:0], 2'b00};
			default:   src_b = reg_b;
		endcase
	end

	mips_alu u_alu (
		.a      (src_a),
		.b      (src_b),
		.op     (ctrl.alu_op),
		.result (alu_res),
		.zero   (alu_zero)
	);

	// writeback dest and data, jal links the already-advanced pc
	always_comb begin
		case (ctrl.reg_dst)
			dst_rd:  reg_wr_addr = ir[15:11];
			dst_ra:  reg_wr_addr = reg_ra;
			default: reg_wr_addr = ir[20:16];
		endcase
		if (ctrl.reg_dst == dst_ra)
			reg_wr_data = pc;
		else
			reg_wr_data = ctrl.mem_to_reg ? mdr : alu_out;
	end

	assign reg_wr_valid = ctrl.reg_wr;

	mips_regfile u_rf (
		.clk      (clk),
		.rstb     (rstb),
		.rd_addr1 (ir[25:21]),
		.rd_addr2 (ir[20:16]),
		.wr_addr  (reg_wr_addr),
		.wr_data  (reg_wr_data),
		.wr_ena   (ctrl.reg_wr),
		.rd_data1 (rd1),
		.rd_data2 (rd2)
	);

	// bus side
	assign mem.addr    = ctrl.iord ? alu_out : pc;
	assign mem.wr_data = reg_b;     // sw data from rt
	assign mem.wr_ena  = ctrl.mem_wr;

	assign pc_ena = ctrl.pc_wr || (ctrl.branch_eq && alu_zero) ||
		(ctrl.branch_ne && !alu_zero);

	always_ff @(posedge clk) begin
		if (!rstb) begin
			pc <= '0;
			ir <= '0;
		end else begin
			if (ctrl.ir_wr)
				ir <= mem.rd_data;
			if (pc_ena) begin
				case (ctrl.pc_src)
					pcs_alu:     pc <= alu_res;
					pcs_alu_out: pc <= alu_out;
					pcs_jump:    pc <= {pc[31:28], ir[25:0], 2'b00};
					pcs_reg_a:   pc <= reg_a;
					default:     pc <= alu_res;
				endcase
			end
		end
	end

	// inter-state payload, reloaded every cycle
	always_ff @(posedge clk) begin
		reg_a   <= rd1;
		reg_b   <= rd2;
		alu_out <= alu_res;
		mdr     <= mem.rd_data;   // used only after mem_rd
	end

endmodule

/* hdl/mips_control.sv */
`timescale 1ns/10ps

module mips_control (
	input  logic                      clk,
	input  logic                      rstb,
	input  logic [mips_pkg::xlen-1:0] instr,
	output mips_pkg::ctrl_word_t      ctrl
);
	import mips_pkg::*;

	ctrl_state_e state, state_nxt;
	logic [5:0]  opcode;
	logic [5:0]  funct;
	logic        funct_ok;   // supported alu funct, jr excluded

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign funct_ok = (funct == fn_addu) || (funct == fn_subu) || (funct == fn_and) ||
		(funct == fn_or) || (funct == fn_slt) || (funct == fn_sll);

	always_ff @(posedge clk) begin
		if (!rstb)
			state <= st_fetch;
		else
			state <= state_nxt;
	end

	// sequencing, unknown encodings drop back to fetch
	always_comb begin
		state_nxt = st_fetch;
		case (state)
			st_fetch: state_nxt = st_decode;
			st_decode: begin
				case (opcode)
					op_rtype: begin
						if (funct == fn_jr)
							state_nxt = st_jr;
						else if (funct_ok)
							state_nxt = st_exec_r;
					end
					op_addiu, op_andi, op_ori: state_nxt = st_exec_i;
					op_lw, op_sw:              state_nxt = st_addr;
					op_beq, op_bne:            state_nxt = st_branch;
					op_j, op_jal:              state_nxt = st_jump;
					default:                   state_nxt = st_fetch;
				endcase
			end
			st_exec_r, st_exec_i: state_nxt = st_wb_alu;
			st_addr:   state_nxt = (opcode == op_lw) ? st_mem_rd : st_mem_wr;
			st_mem_rd: state_nxt = st_wb_mem;
			default:   state_nxt = st_fetch;   // wb, mem_wr, branch, jump, jr
		endcase
	end

	// control word, state plus the held IR
	always_comb begin
		ctrl = '0;
		ctrl.alu_op = alu_add;
		case (state)
			st_fetch: begin
				ctrl.ir_wr  = 1'b1;
				ctrl.pc_wr  = 1'b1;     // pc <= pc + 4
				ctrl.src_a  = sa_pc;
				ctrl.src_b  = sb_four;
				ctrl.pc_src = pcs_alu;
			end
			st_decode: begin
				ctrl.src_a = sa_pc;     // speculative branch target into alu_out
				ctrl.src_b = sb_imm_sh;
			end
			st_exec_r: begin
				ctrl.src_a = (funct == fn_sll) ? sa_shamt : sa_reg_a;
				ctrl.src_b = sb_reg_b;
				case (funct)
					fn_subu: ctrl.alu_op = alu_sub;
					fn_and:  ctrl.alu_op = alu_and;
					fn_or:   ctrl.alu_op = alu_or;
					fn_slt:  ctrl.alu_op = alu_slt;
					fn_sll:  ctrl.alu_op = alu_sll;
					default: ctrl.alu_op = alu_add;
				endcase
			end
			st_exec_i: begin
				ctrl.src_a    = sa_reg_a;
				ctrl.src_b    = sb_imm;
				ctrl.ext_zero = (opcode == op_andi) || (opcode == op_ori);
				if (opcode == op_andi)
					ctrl.alu_op = alu_and;
				else if (opcode == op_ori)
					ctrl.alu_op = alu_or;
			end
			st_addr: begin
				ctrl.src_a = sa_reg_a;  // base + sext offset
				ctrl.src_b = sb_imm;
			end
			st_mem_rd: ctrl.iord = 1'b1;
			st_mem_wr: begin
				ctrl.iord   = 1'b1;
				ctrl.mem_wr = 1'b1;
			end
			st_wb_mem: begin
				ctrl.reg_wr     = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.reg_dst    = dst_rt;
			end
			st_wb_alu: begin
				ctrl.reg_wr  = 1'b1;
				ctrl.reg_dst = (opcode == op_rtype) ? dst_rd : dst_rt;
			end
			st_branch: begin
				ctrl.src_a     = sa_reg_a;
				ctrl.src_b     = sb_reg_b;
				ctrl.alu_op    = alu_sub;
				ctrl.branch_eq = (opcode == op_beq);
				ctrl.branch_ne = (opcode == op_bne);
				ctrl.pc_src    = pcs_alu_out;
			end
			st_jump: begin
				ctrl.pc_wr   = 1'b1;
				ctrl.pc_src  = pcs_jump;
				ctrl.reg_wr  = (opcode == op_jal);  // link with pc, already +4
				ctrl.reg_dst = dst_ra;
			end
			st_jr: begin
				ctrl.pc_wr  = 1'b1;
				ctrl.pc_src = pcs_reg_a;
			end
			default: ctrl = '0;
		endcase
	end

	// IR loads only in fetch
	a_ir_wr_fetch: assert property (@(posedge clk) disable iff (!rstb)
		ctrl.ir_wr |-> state == st_fetch);
	a_no_wr_on_fetch: assert property (@(posedge clk) disable iff (!rstb)
		!(ctrl.mem_wr && ctrl.ir_wr));

endmodule

/* hdl/mips_regfile.sv */
`timescale 1ns/10ps

module mips_regfile (
	input  logic                      clk,
	input  logic                      rstb,
	input  logic [4:0]                rd_addr1,
	input  logic [4:0]                rd_addr2,
	input  logic [4:0]                wr_addr,
	input  logic [mips_pkg::xlen-1:0] wr_data,
	input  logic                      wr_ena,
	output logic [mips_pkg::xlen-1:0] rd_data1,
	output logic [mips_pkg::xlen-1:0] rd_data2
);
	import mips_pkg::*;

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rstb) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_ena && wr_addr != 5'd0) begin
			regs[wr_addr] <= wr_data;   // $0 never stored
		end
	end

	// async reads, $0 hardwired
	assign rd_data1 = (rd_addr1 == 5'd0) ? '0 : regs[rd_addr1];
	assign rd_data2 = (rd_addr2 == 5'd0) ? '0 : regs[rd_addr2];

	// wb mux must resolve before the write strobe
	a_wr_addr_known: assert property (@(posedge clk) disable iff (!rstb)
		wr_ena |-> !$isunknown(wr_addr));

endmodule

/* hdl/mips_alu.sv */
`timescale 1ns/10ps

module mips_alu (
	input  logic [mips_pkg::xlen-1:0] a,
	input  logic [mips_pkg::xlen-1:0] b,
	input  mips_pkg::alu_op_e         op,
	output logic [mips_pkg::xlen-1:0] result,
	output logic                      zero
);
	import mips_pkg::*;

	logic [xlen-1:0] diff;

	assign diff = a - b;    // sub path

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = diff;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			// signed compare, overflow-safe form
			alu_slt: result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
			// a carries shamt, b the value from rt
			alu_sll: result = b << a[4:0];
			default: result = a + b;
		endcase
	end

	assign zero = (result == '0);   // beq/bne condition

endmodule

/* hdl/mem_bus_if.sv */
`timescale 1ns/10ps

// core <-> unified memory, no handshake
// rd_data valid same cycle as addr, writes land on next edge
interface mem_bus_if;
	import mips_pkg::*;

	logic [xlen-1:0] addr;      // byte address
	logic [xlen-1:0] wr_data;
	logic            wr_ena;
	logic [xlen-1:0] rd_data;

	modport core (
		output addr, wr_data, wr_ena,
		input  rd_data
	);

	modport mem (
		input  addr, wr_data, wr_ena,
		output rd_data
	);

endinterface

/* hdl/mips_pkg.sv */
package mips_pkg;

	localparam int xlen      = 32;
	localparam int mem_words = 256;
	localparam int mem_aw    = 8;            // word address bits, mem_words deep
	localparam logic [4:0] reg_ra = 5'd31;   // link register for jal

	// opcodes, instr[31:26]
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_j     = 6'h02;
	localparam logic [5:0] op_jal   = 6'h03;
	localparam logic [5:0] op_beq   = 6'h04;
	localparam logic [5:0] op_bne   = 6'h05;
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_andi  = 6'h0c;
	localparam logic [5:0] op_ori   = 6'h0d;
	localparam logic [5:0] op_lw    = 6'h23;
	localparam logic [5:0] op_sw    = 6'h2b;

	// funct codes for op_rtype, instr[5:0]
	localparam logic [5:0] fn_sll  = 6'h00;
	localparam logic [5:0] fn_jr   = 6'h08;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_slt  = 6'h2a;

	// mux select codes carried in the control word
	localparam logic [1:0] pcs_alu     = 2'd0;   // pc+4 straight from alu
	localparam logic [1:0] pcs_alu_out = 2'd1;   // branch target from decode
	localparam logic [1:0] pcs_jump    = 2'd2;
	localparam logic [1:0] pcs_reg_a   = 2'd3;   // jr
	localparam logic [1:0] dst_rt = 2'd0;
	localparam logic [1:0] dst_rd = 2'd1;
	localparam logic [1:0] dst_ra = 2'd2;
	localparam logic [1:0] sa_pc    = 2'd0;
	localparam logic [1:0] sa_reg_a = 2'd1;
	localparam logic [1:0] sa_shamt = 2'd2;
	localparam logic [1:0] sb_reg_b  = 2'd0;
	localparam logic [1:0] sb_four   = 2'd1;
	localparam logic [1:0] sb_imm    = 2'd2;
	localparam logic [1:0] sb_imm_sh = 2'd3;     // imm << 2, branch offset

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_sll
	} alu_op_e;

	typedef enum logic [3:0] {
		st_fetch, st_decode, st_exec_r, st_exec_i, st_addr, st_mem_rd,
		st_mem_wr, st_wb_mem, st_wb_alu, st_branch, st_jump, st_jr
	} ctrl_state_e;

	typedef struct packed {
		logic       pc_wr;
		logic       branch_eq;
		logic       branch_ne;
		logic [1:0] pc_src;
		logic       iord;       // 1 = data address from alu_out
		logic       mem_wr;
		logic       ir_wr;
		logic       reg_wr;
		logic       mem_to_reg;
		logic [1:0] reg_dst;
		logic [1:0] src_a;
		logic [1:0] src_b;
		logic       ext_zero;   // zero-extend for andi/ori
		alu_op_e    alu_op;
	} ctrl_word_t;

endpackage
